/* common/isa_pkg.sv */
// RV32I subset: major opcodes, ALU funct3 codes, funct7 values, instruction field positions
package isa_pkg;

	localparam int INST_W    = 32;
	localparam int REG_IDX_W = 5;

	//////////////////////////////
	// instruction fields
	//////////////////////////////

	localparam int OPCODE_LSB = 0;
	localparam int OPCODE_MSB = 6;
	localparam int RD_LSB     = 7;
	localparam int RD_MSB     = 11;
	localparam int FUNCT3_LSB = 12;
	localparam int FUNCT3_MSB = 14;
	localparam int RS1_LSB    = 15;
	localparam int RS1_MSB    = 19;
	localparam int RS2_LSB    = 20;
	localparam int RS2_MSB    = 24;
	localparam int FUNCT7_LSB = 25;
	localparam int FUNCT7_MSB = 31;

	localparam logic [6:0] F7_BASE = 7'b0000000; // plain alu op
	localparam logic [6:0] F7_ALT  = 7'b0100000; // sub / sra

	//////////////////////////////
	// major opcodes
	//////////////////////////////

	typedef enum logic [6:0] {
		R_TYPE = 7'b0110011, // reg-reg alu
		I_TYPE = 7'b0010011, // reg-imm alu
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		BRANCH = 7'b1100011, // conditional branches
		LUI    = 7'b0110111,
		JAL    = 7'b1101111
	} opcode_e;

	//////////////////////////////
	// alu group funct3
	//////////////////////////////

	// shift and add/sub pairs are split by funct7
	typedef enum logic [2:0] {
		ADD_SUB = 3'b000,
		SLL     = 3'b001,
		SLT     = 3'b010,
		SLTU    = 3'b011,
		XOR     = 3'b100,
		SRL_SRA = 3'b101,
		OR      = 3'b110,
		AND     = 3'b111
	} funct3_e;

endpackage

/* common/dp_pkg.sv */
// dispatch types: ALU function, unit class, operand selects; lane count and space width
package dp_pkg;

	//////////////////////////////
	// dispatch constants
	//////////////////////////////

	localparam int N_LANE  = 2; // instructions per cycle
	localparam int SPACE_W = 2; // holds 0..N_LANE

	//////////////////////////////
	// alu function
	//////////////////////////////

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_SLL  = 4'd2,
		ALU_SLT  = 4'd3,
		ALU_SLTU = 4'd4,
		ALU_XOR  = 4'd5,
		ALU_SRL  = 4'd6,
		ALU_SRA  = 4'd7,
		ALU_OR   = 4'd8,
		ALU_AND  = 4'd9
	} alu_func_e;

	//////////////////////////////
	// unit class
	//////////////////////////////

	typedef enum logic [1:0] {
		FU_ALU    = 2'd0,
		FU_MEM    = 2'd1, // loads and stores
		FU_BRANCH = 2'd2  // branches and jal
	} fu_type_e;

	//////////////////////////////
	// operand selects
	//////////////////////////////

	typedef enum logic [1:0] {
		OPA_RS1  = 2'd0,
		OPA_PC   = 2'd1, // branch / jump target
		OPA_ZERO = 2'd2  // lui
	} opa_sel_e;

	typedef enum logic {
		OPB_RS2 = 1'b0,
		OPB_IMM = 1'b1
	} opb_sel_e;

endpackage

/* verilog/regfile.sv */
// architectural register file: four read ports, two write ports, write forwarding, x0 fixed at zero
`timescale 1ns/1ps

module regfile #(
	parameter int XLEN = 32
) (
	input  logic                                                clock,
	input  logic                                                arst_n,
	input  logic [2*dp_pkg::N_LANE-1:0][isa_pkg::REG_IDX_W-1:0] rd_idx,
	input  logic [dp_pkg::N_LANE-1:0]                           wr_en,
	input  logic [dp_pkg::N_LANE-1:0][isa_pkg::REG_IDX_W-1:0]   wr_idx,
	input  logic [dp_pkg::N_LANE-1:0][XLEN-1:0]                 wr_data,
	output logic [2*dp_pkg::N_LANE-1:0][XLEN-1:0]               rd_data
);

	localparam int N_RD  = 2 * dp_pkg::N_LANE;
	localparam int N_WR  = dp_pkg::N_LANE;
	localparam int N_REG = 2 ** isa_pkg::REG_IDX_W;

	logic [XLEN-1:0] regs [1:N_REG-1]; // x0 has no storage

	//////////////////////////////
	// write ports
	//////////////////////////////

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int k = 1; k < N_REG; k++) begin
				regs[k] <= '0;
			end
		end else begin
			for (int w = 0; w < N_WR; w++) begin
				if (wr_en[w] && wr_idx[w] != '0) begin
					regs[wr_idx[w]] <= wr_data[w]; // later lane overrides
				end
			end
		end
	end

	//////////////////////////////
	// read ports
	//////////////////////////////

	always_comb begin
		for (int r = 0; r < N_RD; r++) begin
			rd_data[r] = '0;
			if (rd_idx[r] != '0) begin
				rd_data[r] = regs[rd_idx[r]];
				// bypass this cycle's retire, lane 1 last so it wins
				for (int w = 0; w < N_WR; w++) begin
					if (wr_en[w] && wr_idx[w] == rd_idx[r]) begin
						rd_data[r] = wr_data[w];
					end
				end
			end
		end
	end

endmodule

/* dispatch/dp_decoder.sv */
// one-lane RV32I decoder: control fields, register indices, sign-extended immediate
`timescale 1ns/1ps

module dp_decoder #(
	parameter int XLEN = 32
) (
	input  logic [isa_pkg::INST_W-1:0]    inst,
	input  logic                          valid,
	output dp_pkg::alu_func_e             alu_func,
	output dp_pkg::fu_type_e              fu_sel,
	output dp_pkg::opa_sel_e              opa_sel,
	output dp_pkg::opb_sel_e              opb_sel,
	output logic [XLEN-1:0]               imm,
	output logic [isa_pkg::REG_IDX_W-1:0] rs1_idx,
	output logic [isa_pkg::REG_IDX_W-1:0] rs2_idx,
	output logic [isa_pkg::REG_IDX_W-1:0] dest_idx,
	output logic                          has_dest,
	output logic                          illegal
);

	isa_pkg::opcode_e opcode;
	isa_pkg::funct3_e funct3;
	logic [2:0]       f3_raw;
	logic [6:0]       funct7;
	logic             alt_f7;
	logic [XLEN-1:0]  imm_i;
	logic [XLEN-1:0]  imm_s;
	logic [XLEN-1:0]  imm_b;
	logic [XLEN-1:0]  imm_u;
	logic [XLEN-1:0]  imm_j;
	logic             uses_rs1;
	logic             uses_rs2;
	logic             writes_rd;
	logic             bad_code;

	// shared by reg-reg and reg-imm forms
	function automatic dp_pkg::alu_func_e alu_of(input isa_pkg::funct3_e f3, input logic alt);
		case (f3)
			isa_pkg::ADD_SUB: return alt ? dp_pkg::ALU_SUB : dp_pkg::ALU_ADD;
			isa_pkg::SLL:     return dp_pkg::ALU_SLL;
			isa_pkg::SLT:     return dp_pkg::ALU_SLT;
			isa_pkg::SLTU:    return dp_pkg::ALU_SLTU;
			isa_pkg::XOR:     return dp_pkg::ALU_XOR;
			isa_pkg::SRL_SRA: return alt ? dp_pkg::ALU_SRA : dp_pkg::ALU_SRL;
			isa_pkg::OR:      return dp_pkg::ALU_OR;
			default:          return dp_pkg::ALU_AND;
		endcase
	endfunction

	assign opcode = isa_pkg::opcode_e'(inst[isa_pkg::OPCODE_MSB:isa_pkg::OPCODE_LSB]);
	assign f3_raw = inst[isa_pkg::FUNCT3_MSB:isa_pkg::FUNCT3_LSB];
	assign funct3 = isa_pkg::funct3_e'(f3_raw);
	assign funct7 = inst[isa_pkg::FUNCT7_MSB:isa_pkg::FUNCT7_LSB];
	assign alt_f7 = (funct7 == isa_pkg::F7_ALT);

	//////////////////////////////
	// immediates
	//////////////////////////////

	assign imm_i = XLEN'($signed(inst[31:20]));
	assign imm_s = XLEN'($signed({inst[31:25], inst[11:7]}));
	assign imm_b = XLEN'($signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}));
	assign imm_u = XLEN'($signed({inst[31:12], 12'b0}));
	assign imm_j = XLEN'($signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}));

	//////////////////////////////
	// class decode
	//////////////////////////////

	always_comb begin
		alu_func  = dp_pkg::ALU_ADD; // address / target adds by default
		fu_sel    = dp_pkg::FU_ALU;
		opa_sel   = dp_pkg::OPA_RS1;
		opb_sel   = dp_pkg::OPB_IMM;
		imm       = '0;
		uses_rs1  = 1'b0;
		uses_rs2  = 1'b0;
		writes_rd = 1'b0;
		bad_code  = 1'b0;
		case (opcode)
			isa_pkg::R_TYPE: begin
				alu_func  = alu_of(funct3, alt_f7);
				opb_sel   = dp_pkg::OPB_RS2;
				uses_rs1  = 1'b1;
				uses_rs2  = 1'b1;
				writes_rd = 1'b1;
				// alt funct7 only exists for sub and sra
				bad_code  = !(funct7 == isa_pkg::F7_BASE ||
					(alt_f7 && (funct3 == isa_pkg::ADD_SUB || funct3 == isa_pkg::SRL_SRA)));
			end
			isa_pkg::I_TYPE: begin
				alu_func  = alu_of(funct3, alt_f7 && funct3 == isa_pkg::SRL_SRA); // no subi
				imm       = imm_i;
				uses_rs1  = 1'b1;
				writes_rd = 1'b1;
				if (funct3 == isa_pkg::SLL) begin
					bad_code = (funct7 != isa_pkg::F7_BASE);
				end else if (funct3 == isa_pkg::SRL_SRA) begin
					bad_code = !(funct7 == isa_pkg::F7_BASE || alt_f7);
				end
			end
			isa_pkg::LOAD: begin
				fu_sel    = dp_pkg::FU_MEM;
				imm       = imm_i;
				uses_rs1  = 1'b1;
				writes_rd = 1'b1;
				bad_code  = (f3_raw[1:0] == 2'b11) || (f3_raw == 3'b110); // lb..lhu only
			end
			isa_pkg::STORE: begin
				fu_sel   = dp_pkg::FU_MEM;
				imm      = imm_s;
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1; // store data
				bad_code = f3_raw[2] || (f3_raw[1:0] == 2'b11);
			end
			isa_pkg::BRANCH: begin
				fu_sel   = dp_pkg::FU_BRANCH;
				opa_sel  = dp_pkg::OPA_PC;
				imm      = imm_b;
				uses_rs1 = 1'b1; // compared by the branch unit
				uses_rs2 = 1'b1;
				bad_code = (f3_raw[2:1] == 2'b01);
			end
			isa_pkg::LUI: begin
				opa_sel   = dp_pkg::OPA_ZERO;
				imm       = imm_u;
				writes_rd = 1'b1;
			end
			isa_pkg::JAL: begin
				fu_sel    = dp_pkg::FU_BRANCH;
				opa_sel   = dp_pkg::OPA_PC;
				imm       = imm_j;
				writes_rd = 1'b1; // link address
			end
			default: begin
				opb_sel  = dp_pkg::OPB_RS2;
				bad_code = 1'b1;
			end
		endcase
	end

	// unused sources read x0
	assign rs1_idx  = uses_rs1 ? inst[isa_pkg::RS1_MSB:isa_pkg::RS1_LSB] : '0;
	assign rs2_idx  = uses_rs2 ? inst[isa_pkg::RS2_MSB:isa_pkg::RS2_LSB] : '0;
	assign has_dest = writes_rd && !bad_code; // illegal ops never write back
	assign dest_idx = has_dest ? inst[isa_pkg::RD_MSB:isa_pkg::RD_LSB] : '0;
	assign illegal  = valid && bad_code;

endmodule

/* dispatch/dp_ctrl.sv */
// dispatch controller: lane count from free spaces, in-order lane take, registered valids
`timescale 1ns/1ps

module dp_ctrl (
	input  logic                        clock,
	input  logic                        arst_n,
	input  logic [dp_pkg::N_LANE-1:0]   if_valid,
	input  logic [dp_pkg::SPACE_W-1:0]  rob_spaces,
	input  logic [dp_pkg::SPACE_W-1:0]  rs_spaces,
	input  logic [dp_pkg::SPACE_W-1:0]  lsq_spaces,
	output logic [dp_pkg::SPACE_W-1:0]  dp_count,
	output logic [dp_pkg::N_LANE-1:0]   lane_take,
	output logic [dp_pkg::N_LANE-1:0]   dp_valid
);

	localparam int SW = dp_pkg::SPACE_W;

	logic [SW-1:0] limit;
	logic          in_order;

	//////////////////////////////
	// space limit
	//////////////////////////////

	always_comb begin
		limit = (rob_spaces <= rs_spaces) ? rob_spaces : rs_spaces;
		if (lsq_spaces < limit) begin
			limit = lsq_spaces;
		end
	end

	//////////////////////////////
	// lane take and count
	//////////////////////////////

	// a lane leaves only behind an older taken lane
	always_comb begin
		lane_take = '0;
		dp_count  = '0;
		in_order  = 1'b1;
		for (int i = 0; i < dp_pkg::N_LANE; i++) begin
			lane_take[i] = in_order && if_valid[i] && (int'(limit) > i);
			in_order     = lane_take[i];
			if (lane_take[i]) begin
				dp_count = dp_count + SW'(1);
			end
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			dp_valid <= '0;
		end else begin
			dp_valid <= lane_take; // packet valid one cycle later
		end
	end

endmodule

/* dispatch/dp_stage.sv */
// two-wide dispatch stage: lane decoders, register file reads, controller, output packet registers
`timescale 1ns/1ps

module dp_stage #(
	parameter int XLEN = 32
) (
	input  logic                                               clock,
	input  logic                                               arst_n,
	// fetch
	input  logic [dp_pkg::N_LANE-1:0]                          if_valid,
	input  logic [dp_pkg::N_LANE-1:0][isa_pkg::INST_W-1:0]     if_inst,
	input  logic [dp_pkg::N_LANE-1:0][XLEN-1:0]                if_pc,
	// retire writes
	input  logic [dp_pkg::N_LANE-1:0]                          rt_valid,
	input  logic [dp_pkg::N_LANE-1:0][isa_pkg::REG_IDX_W-1:0]  rt_idx,
	input  logic [dp_pkg::N_LANE-1:0][XLEN-1:0]                rt_data,
	// back-end free spaces
	input  logic [dp_pkg::SPACE_W-1:0]                         rob_spaces,
	input  logic [dp_pkg::SPACE_W-1:0]                         rs_spaces,
	input  logic [dp_pkg::SPACE_W-1:0]                         lsq_spaces,
	output logic [dp_pkg::SPACE_W-1:0]                         dp_count,
	// dispatched packets
	output logic [dp_pkg::N_LANE-1:0]                          dp_valid,
	output logic [dp_pkg::N_LANE-1:0][XLEN-1:0]                dp_pc,
	output dp_pkg::alu_func_e [dp_pkg::N_LANE-1:0]             dp_alu_func,
	output dp_pkg::fu_type_e [dp_pkg::N_LANE-1:0]              dp_fu_sel,
	output dp_pkg::opa_sel_e [dp_pkg::N_LANE-1:0]              dp_opa_sel,
	output dp_pkg::opb_sel_e [dp_pkg::N_LANE-1:0]              dp_opb_sel,
	output logic [dp_pkg::N_LANE-1:0][XLEN-1:0]                dp_imm,
	output logic [dp_pkg::N_LANE-1:0][isa_pkg::REG_IDX_W-1:0]  dp_rs1_idx,
	output logic [dp_pkg::N_LANE-1:0][isa_pkg::REG_IDX_W-1:0]  dp_rs2_idx,
	output logic [dp_pkg::N_LANE-1:0][XLEN-1:0]                dp_rs1_value,
	output logic [dp_pkg::N_LANE-1:0][XLEN-1:0]                dp_rs2_value,
	output logic [dp_pkg::N_LANE-1:0][isa_pkg::REG_IDX_W-1:0]  dp_dest_idx,
	output logic [dp_pkg::N_LANE-1:0]                          dp_has_dest,
	output logic [dp_pkg::N_LANE-1:0]                          dp_illegal
);

	dp_pkg::alu_func_e [dp_pkg::N_LANE-1:0]                dec_alu_func;
	dp_pkg::fu_type_e [dp_pkg::N_LANE-1:0]                 dec_fu_sel;
	dp_pkg::opa_sel_e [dp_pkg::N_LANE-1:0]                 dec_opa_sel;
	dp_pkg::opb_sel_e [dp_pkg::N_LANE-1:0]                 dec_opb_sel;
	logic [dp_pkg::N_LANE-1:0][XLEN-1:0]                   dec_imm;
	logic [dp_pkg::N_LANE-1:0][isa_pkg::REG_IDX_W-1:0]     dec_rs1_idx;
	logic [dp_pkg::N_LANE-1:0][isa_pkg::REG_IDX_W-1:0]     dec_rs2_idx;
	logic [dp_pkg::N_LANE-1:0][isa_pkg::REG_IDX_W-1:0]     dec_dest_idx;
	logic [dp_pkg::N_LANE-1:0]                             dec_has_dest;
	logic [dp_pkg::N_LANE-1:0]                             dec_illegal;
	logic [2*dp_pkg::N_LANE-1:0][isa_pkg::REG_IDX_W-1:0]   rf_rd_idx; // rs1, rs2 per lane
	logic [2*dp_pkg::N_LANE-1:0][XLEN-1:0]                 rf_rd_data;
	logic [dp_pkg::N_LANE-1:0]                             lane_take;

	//////////////////////////////
	// per-lane decode
	//////////////////////////////

	for (genvar i = 0; i < dp_pkg::N_LANE; i++) begin : g_lane
		dp_decoder #(.XLEN(XLEN)) i_dp_decoder (
			.inst     (if_inst[i]),
			.valid    (if_valid[i]),
			.alu_func (dec_alu_func[i]),
			.fu_sel   (dec_fu_sel[i]),
			.opa_sel  (dec_opa_sel[i]),
			.opb_sel  (dec_opb_sel[i]),
			.imm      (dec_imm[i]),
			.rs1_idx  (dec_rs1_idx[i]),
			.rs2_idx  (dec_rs2_idx[i]),
			.dest_idx (dec_dest_idx[i]),
			.has_dest (dec_has_dest[i]),
			.illegal  (dec_illegal[i])
		);
		assign rf_rd_idx[2*i]   = dec_rs1_idx[i];
		assign rf_rd_idx[2*i+1] = dec_rs2_idx[i];
	end

	regfile #(.XLEN(XLEN)) i_regfile (
		.clock   (clock),
		.arst_n  (arst_n),
		.rd_idx  (rf_rd_idx),
		.wr_en   (rt_valid),
		.wr_idx  (rt_idx),
		.wr_data (rt_data),
		.rd_data (rf_rd_data)
	);

	dp_ctrl i_dp_ctrl (
		.clock      (clock),
		.arst_n     (arst_n),
		.if_valid   (if_valid),
		.rob_spaces (rob_spaces),
		.rs_spaces  (rs_spaces),
		.lsq_spaces (lsq_spaces),
		.dp_count   (dp_count),
		.lane_take  (lane_take),
		.dp_valid   (dp_valid)
	);

	//////////////////////////////
	// output packets
	//////////////////////////////

	// untaken lanes hold their old fields
	always_ff @(posedge clock) begin
		for (int i = 0; i < dp_pkg::N_LANE; i++) begin
			if (lane_take[i]) begin
				dp_pc[i]        <= if_pc[i];
				dp_alu_func[i]  <= dec_alu_func[i];
				dp_fu_sel[i]    <= dec_fu_sel[i];
				dp_opa_sel[i]   <= dec_opa_sel[i];
				dp_opb_sel[i]   <= dec_opb_sel[i];
				dp_imm[i]       <= dec_imm[i];
				dp_rs1_idx[i]   <= dec_rs1_idx[i];
				dp_rs2_idx[i]   <= dec_rs2_idx[i];
				dp_rs1_value[i] <= rf_rd_data[2*i];   // includes same-cycle retire
				dp_rs2_value[i] <= rf_rd_data[2*i+1];
				dp_dest_idx[i]  <= dec_dest_idx[i];
				dp_has_dest[i]  <= dec_has_dest[i];
				dp_illegal[i]   <= dec_illegal[i];
			end
		end
	end

endmodule

/* verification/dp_assert.sv */
// bound checker for the dispatch stage: lane order, count limit, reset valids, x0 operand data
`timescale 1ns/1ps

module dp_assert #(
	parameter int XLEN = 32
) (
	input logic                                              clock,
	input logic                                              arst_n,
	input logic [dp_pkg::SPACE_W-1:0]                        rob_spaces,
	input logic [dp_pkg::SPACE_W-1:0]                        rs_spaces,
	input logic [dp_pkg::SPACE_W-1:0]                        lsq_spaces,
	input logic [dp_pkg::SPACE_W-1:0]                        dp_count,
	input logic [dp_pkg::N_LANE-1:0]                         dp_valid,
	input logic [dp_pkg::N_LANE-1:0][isa_pkg::REG_IDX_W-1:0] dp_rs1_idx,
	input logic [dp_pkg::N_LANE-1:0][isa_pkg::REG_IDX_W-1:0] dp_rs2_idx,
	input logic [dp_pkg::N_LANE-1:0][XLEN-1:0]               dp_rs1_value,
	input logic [dp_pkg::N_LANE-1:0][XLEN-1:0]               dp_rs2_value
);

	logic bad_order = 1'b0;
	logic bad_count = 1'b0;
	logic bad_reset = 1'b0;
	logic bad_x0    = 1'b0;
	logic x0_clean;
	logic any_fail;

	// valid lanes reading x0 must carry zero
	always_comb begin
		x0_clean = 1'b1;
		for (int i = 0; i < dp_pkg::N_LANE; i++) begin
			if (dp_valid[i] && dp_rs1_idx[i] == '0 && dp_rs1_value[i] != '0) begin
				x0_clean = 1'b0;
			end
			if (dp_valid[i] && dp_rs2_idx[i] == '0 && dp_rs2_value[i] != '0) begin
				x0_clean = 1'b0;
			end
		end
	end

	assign any_fail = bad_order | bad_count | bad_reset | bad_x0;

	//////////////////////////////
	// properties
	//////////////////////////////

	a_order: assert property (@(posedge clock) disable iff (!arst_n)
		dp_valid[1] |-> dp_valid[0])
		else begin
			$error("lane 1 dispatched without lane 0");
			bad_order = 1'b1;
		end

	a_count: assert property (@(posedge clock) disable iff (!arst_n)
		dp_count <= rob_spaces && dp_count <= rs_spaces && dp_count <= lsq_spaces)
		else begin
			$error("dispatch count above a free space");
			bad_count = 1'b1;
		end

	a_reset: assert property (@(posedge clock) !arst_n |-> dp_valid == '0)
		else begin
			$error("packet valid while in reset");
			bad_reset = 1'b1;
		end

	a_x0: assert property (@(posedge clock) disable iff (!arst_n) x0_clean)
		else begin
			$error("x0 source carries nonzero data");
			bad_x0 = 1'b1;
		end

endmodule

bind dp_stage dp_assert #(.XLEN(XLEN)) i_dp_assert (.*);

/* verification/dp_tb.sv */
// dispatch stage testbench: clock, reset, watchdog, directed tests and compare tasks
`timescale 1ns/1ps

module dp_tb;

	localparam int XLEN    = 32;
	localparam int NL      = dp_pkg::N_LANE;
	localparam int SW      = dp_pkg::SPACE_W;
	localparam int IW      = isa_pkg::REG_IDX_W;
	localparam int CLK_NS  = 10;
	localparam int N_TESTS = 6;

	logic                              clock = 1'b0;
	logic                              arst_n;
	logic [NL-1:0]                     if_valid;
	logic [NL-1:0][isa_pkg::INST_W-1:0] if_inst;
	logic [NL-1:0][XLEN-1:0]           if_pc;
	logic [NL-1:0]                     rt_valid;
	logic [NL-1:0][IW-1:0]             rt_idx;
	logic [NL-1:0][XLEN-1:0]           rt_data;
	logic [SW-1:0]                     rob_spaces;
	logic [SW-1:0]                     rs_spaces;
	logic [SW-1:0]                     lsq_spaces;
	logic [SW-1:0]                     dp_count;
	logic [NL-1:0]                     dp_valid;
	logic [NL-1:0][XLEN-1:0]           dp_pc;
	dp_pkg::alu_func_e [NL-1:0]        dp_alu_func;
	dp_pkg::fu_type_e [NL-1:0]         dp_fu_sel;
	dp_pkg::opa_sel_e [NL-1:0]         dp_opa_sel;
	dp_pkg::opb_sel_e [NL-1:0]         dp_opb_sel;
	logic [NL-1:0][XLEN-1:0]           dp_imm;
	logic [NL-1:0][IW-1:0]             dp_rs1_idx;
	logic [NL-1:0][IW-1:0]             dp_rs2_idx;
	logic [NL-1:0][XLEN-1:0]           dp_rs1_value;
	logic [NL-1:0][XLEN-1:0]           dp_rs2_value;
	logic [NL-1:0][IW-1:0]             dp_dest_idx;
	logic [NL-1:0]                     dp_has_dest;
	logic [NL-1:0]                     dp_illegal;
	logic [XLEN-1:0]                   pc_next = 32'h0000_1000;
	logic [XLEN-1:0]                   last_pc;

	dp_stage #(.XLEN(XLEN)) i_dp_stage (.*);

	always #(CLK_NS / 2) clock = ~clock;

	initial begin
		#((N_TESTS * 50 + 100) * CLK_NS);
		abort("timeout: the directed tests did not finish in time");
	end

	//////////////////////////////
	// reporting and compares
	//////////////////////////////

	task automatic abort(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_mismatch(input string name, input logic [XLEN-1:0] exp, act);
		abort($sformatf("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, exp, act));
	endtask

	task automatic check_alu(input string name, input dp_pkg::alu_func_e exp, act);
		if (act !== exp) report_mismatch(name, XLEN'(exp), XLEN'(act));
	endtask
	task automatic check_fu(input string name, input dp_pkg::fu_type_e exp, act);
		if (act !== exp) report_mismatch(name, XLEN'(exp), XLEN'(act));
	endtask
	task automatic check_opa(input string name, input dp_pkg::opa_sel_e exp, act);
		if (act !== exp) report_mismatch(name, XLEN'(exp), XLEN'(act));
	endtask
	task automatic check_opb(input string name, input dp_pkg::opb_sel_e exp, act);
		if (act !== exp) report_mismatch(name, XLEN'(exp), XLEN'(act));
	endtask
	task automatic check_data(input string name, input logic [XLEN-1:0] exp, act);
		if (act !== exp) report_mismatch(name, exp, act);
	endtask
	task automatic check_idx(input string name, input logic [IW-1:0] exp, act);
		if (act !== exp) report_mismatch(name, XLEN'(exp), XLEN'(act));
	endtask
	task automatic check_count(input string name, input logic [SW-1:0] exp, act);
		if (act !== exp) report_mismatch(name, XLEN'(exp), XLEN'(act));
	endtask
	task automatic check_valid(input string name, input logic [NL-1:0] exp, act);
		if (act !== exp) report_mismatch(name, XLEN'(exp), XLEN'(act));
	endtask
	task automatic check_bit(input string name, input logic exp, act);
		if (act !== exp) report_mismatch(name, XLEN'(exp), XLEN'(act));
	endtask

	//////////////////////////////
	// stimulus helpers
	//////////////////////////////

	function automatic logic [31:0] enc_add(input logic [IW-1:0] rd, rs1, rs2);
		return {isa_pkg::F7_BASE, rs2, rs1, isa_pkg::ADD_SUB, rd, isa_pkg::R_TYPE};
	endfunction

	task automatic fetch(input logic [NL-1:0] v, input logic [31:0] i0, i1);
		last_pc = pc_next;
		if_valid   <= v;
		if_inst[0] <= i0;
		if_inst[1] <= i1;
		if_pc[0]   <= pc_next;
		if_pc[1]   <= pc_next + 32'd4;
		pc_next    = pc_next + 32'd8;
	endtask

	task automatic retire(input logic [NL-1:0] en, input logic [IW-1:0] idx0,
			input logic [XLEN-1:0] d0, input logic [IW-1:0] idx1, input logic [XLEN-1:0] d1);
		rt_valid   <= en;
		rt_idx[0]  <= idx0;
		rt_data[0] <= d0;
		rt_idx[1]  <= idx1;
		rt_data[1] <= d1;
	endtask

	task automatic spaces(input logic [SW-1:0] rob, rs, lsq);
		rob_spaces <= rob;
		rs_spaces  <= rs;
		lsq_spaces <= lsq;
	endtask

	// capture edge, then sample mid-cycle
	task automatic next_cycle();
		@(posedge clock);
		if_valid <= '0;
		rt_valid <= '0;
		@(negedge clock);
	endtask

	//////////////////////////////
	// directed tests
	//////////////////////////////

	task automatic test_reset();
		repeat (3) begin
			@(negedge clock);
			check_valid("dp_valid in reset", 2'b00, dp_valid);
		end
		@(posedge clock);
		arst_n   <= 1'b1; // fourth edge
		if_valid <= '0;
		@(negedge clock);
		check_valid("dp_valid after reset", 2'b00, dp_valid);
	endtask

	task automatic decode_case(input logic [31:0] inst, input dp_pkg::alu_func_e alu,
			input dp_pkg::fu_type_e fu, input dp_pkg::opa_sel_e opa,
			input dp_pkg::opb_sel_e opb, input logic [XLEN-1:0] imm,
			input logic [IW-1:0] rs1, rs2, rd, input logic hd);
		@(posedge clock);
		fetch(2'b01, inst, '0);
		next_cycle();
		check_valid("dp_valid", 2'b01, dp_valid);
		check_data("dp_pc[0]", last_pc, dp_pc[0]);
		check_alu("dp_alu_func[0]", alu, dp_alu_func[0]);
		check_fu("dp_fu_sel[0]", fu, dp_fu_sel[0]);
		check_opa("dp_opa_sel[0]", opa, dp_opa_sel[0]);
		check_opb("dp_opb_sel[0]", opb, dp_opb_sel[0]);
		check_data("dp_imm[0]", imm, dp_imm[0]);
		check_idx("dp_rs1_idx[0]", rs1, dp_rs1_idx[0]);
		check_idx("dp_rs2_idx[0]", rs2, dp_rs2_idx[0]);
		check_idx("dp_dest_idx[0]", rd, dp_dest_idx[0]);
		check_bit("dp_has_dest[0]", hd, dp_has_dest[0]);
		check_bit("dp_illegal[0]", 1'b0, dp_illegal[0]);
	endtask

	task automatic test_decode();
		logic [31:0] r;
		logic [11:0] i12;
		logic [12:0] b13;
		logic [20:0] j21;
		r   = $urandom;
		i12 = r[11:0];
		b13 = {r[12:1], 1'b0}; // branch offsets are even
		j21 = {r[20:1], 1'b0};
		decode_case({7'b0100000, 5'd2, 5'd1, isa_pkg::ADD_SUB, 5'd3, isa_pkg::R_TYPE},
			dp_pkg::ALU_SUB, dp_pkg::FU_ALU, dp_pkg::OPA_RS1, dp_pkg::OPB_RS2,
			'0, 5'd1, 5'd2, 5'd3, 1'b1);
		decode_case({i12, 5'd6, isa_pkg::ADD_SUB, 5'd7, isa_pkg::I_TYPE},
			dp_pkg::ALU_ADD, dp_pkg::FU_ALU, dp_pkg::OPA_RS1, dp_pkg::OPB_IMM,
			{{20{i12[11]}}, i12}, 5'd6, 5'd0, 5'd7, 1'b1);
		decode_case({i12, 5'd9, 3'b010, 5'd8, isa_pkg::LOAD}, // lw
			dp_pkg::ALU_ADD, dp_pkg::FU_MEM, dp_pkg::OPA_RS1, dp_pkg::OPB_IMM,
			{{20{i12[11]}}, i12}, 5'd9, 5'd0, 5'd8, 1'b1);
		decode_case({i12[11:5], 5'd10, 5'd11, 3'b010, i12[4:0], isa_pkg::STORE}, // sw
			dp_pkg::ALU_ADD, dp_pkg::FU_MEM, dp_pkg::OPA_RS1, dp_pkg::OPB_IMM,
			{{20{i12[11]}}, i12}, 5'd11, 5'd10, 5'd0, 1'b0);
		decode_case({b13[12], b13[10:5], 5'd13, 5'd12, 3'b000, b13[4:1], b13[11],
			isa_pkg::BRANCH}, dp_pkg::ALU_ADD, dp_pkg::FU_BRANCH, dp_pkg::OPA_PC,
			dp_pkg::OPB_IMM, {{19{b13[12]}}, b13}, 5'd12, 5'd13, 5'd0, 1'b0);
		decode_case({r[31:12], 5'd14, isa_pkg::LUI},
			dp_pkg::ALU_ADD, dp_pkg::FU_ALU, dp_pkg::OPA_ZERO, dp_pkg::OPB_IMM,
			{r[31:12], 12'h000}, 5'd0, 5'd0, 5'd14, 1'b1);
		decode_case({j21[20], j21[10:1], j21[11], j21[19:12], 5'd1, isa_pkg::JAL},
			dp_pkg::ALU_ADD, dp_pkg::FU_BRANCH, dp_pkg::OPA_PC, dp_pkg::OPB_IMM,
			{{11{j21[20]}}, j21}, 5'd0, 5'd0, 5'd1, 1'b1);
	endtask

	task automatic test_illegal();
		@(posedge clock);
		fetch(2'b11, {25'h0, 7'b1110011}, // system opcode
			{7'b0100000, 5'd2, 5'd1, isa_pkg::XOR, 5'd3, isa_pkg::R_TYPE}); // xor has no alt form
		next_cycle();
		check_valid("dp_valid", 2'b11, dp_valid);
		check_valid("dp_illegal", 2'b11, dp_illegal);
	endtask

	task automatic test_operands();
		logic [XLEN-1:0] d5;
		logic [XLEN-1:0] d6;
		logic [XLEN-1:0] d9;
		logic [XLEN-1:0] da;
		logic [XLEN-1:0] db;
		d5 = $urandom;
		d6 = $urandom;
		d9 = $urandom;
		da = $urandom;
		db = $urandom;
		@(posedge clock);
		retire(2'b11, 5'd5, d5, 5'd6, d6);
		next_cycle();
		@(posedge clock);
		fetch(2'b11, enc_add(5'd7, 5'd5, 5'd6), enc_add(5'd8, 5'd6, 5'd5));
		next_cycle();
		check_data("dp_rs1_value[0]", d5, dp_rs1_value[0]);
		check_data("dp_rs2_value[0]", d6, dp_rs2_value[0]);
		check_data("dp_rs1_value[1]", d6, dp_rs1_value[1]);
		check_data("dp_rs2_value[1]", d5, dp_rs2_value[1]);
		@(posedge clock);
		retire(2'b11, 5'd9, d9, 5'd0, d5); // forwarded x9, ignored x0
		fetch(2'b01, enc_add(5'd1, 5'd9, 5'd0), '0);
		next_cycle();
		check_data("dp_rs1_value[0]", d9, dp_rs1_value[0]);
		check_data("dp_rs2_value[0]", '0, dp_rs2_value[0]);
		@(posedge clock);
		fetch(2'b01, enc_add(5'd1, 5'd0, 5'd9), '0);
		next_cycle();
		check_data("dp_rs1_value[0]", '0, dp_rs1_value[0]);
		check_data("dp_rs2_value[0]", d9, dp_rs2_value[0]);
		@(posedge clock);
		retire(2'b11, 5'd10, da, 5'd10, db); // lane 1 wins
		fetch(2'b01, enc_add(5'd2, 5'd10, 5'd9), '0);
		next_cycle();
		check_data("dp_rs1_value[0]", db, dp_rs1_value[0]);
		@(posedge clock);
		fetch(2'b01, enc_add(5'd3, 5'd0, 5'd10), '0);
		next_cycle();
		check_data("dp_rs2_value[0]", db, dp_rs2_value[0]);
	endtask

	task automatic test_count_sweep();
		int            lim;
		logic [NL-1:0] take;
		for (int rob = 0; rob <= 2; rob++) begin
			for (int rs = 0; rs <= 2; rs++) begin
				for (int lsq = 0; lsq <= 2; lsq++) begin
					for (int v = 0; v < 4; v++) begin
						lim = (rob < rs) ? rob : rs;
						if (lsq < lim) begin
							lim = lsq;
						end
						take[0] = v[0] && lim >= 1;
						take[1] = take[0] && v[1] && lim == 2; // never alone
						@(posedge clock);
						spaces(SW'(rob), SW'(rs), SW'(lsq));
						fetch(NL'(v), enc_add(5'd1, 5'd2, 5'd3), enc_add(5'd4, 5'd5, 5'd6));
						@(negedge clock);
						check_count("dp_count", SW'(int'(take[0]) + int'(take[1])), dp_count);
						next_cycle();
						check_valid("dp_valid", take, dp_valid);
					end
				end
			end
		end
	endtask

	task automatic test_backpressure();
		logic [31:0]     r;
		logic [31:0]     i_lui;
		logic [XLEN-1:0] lui_imm;
		r       = $urandom;
		i_lui   = {r[31:12], 5'd15, isa_pkg::LUI};
		lui_imm = {r[31:12], 12'h000};
		@(posedge clock);
		spaces(2'd2, 2'd0, 2'd2); // rs full
		fetch(2'b11, enc_add(5'd11, 5'd12, 5'd13), i_lui);
		repeat (2) begin
			@(negedge clock);
			check_count("dp_count", 2'd0, dp_count);
			check_valid("dp_valid", 2'b00, dp_valid);
		end
		@(posedge clock);
		spaces(2'd2, 2'd2, 2'd2);
		@(negedge clock);
		check_count("dp_count", 2'd2, dp_count);
		next_cycle();
		check_valid("dp_valid", 2'b11, dp_valid);
		check_data("dp_pc[0]", last_pc, dp_pc[0]);
		check_alu("dp_alu_func[0]", dp_pkg::ALU_ADD, dp_alu_func[0]);
		check_idx("dp_rs1_idx[0]", 5'd12, dp_rs1_idx[0]);
		check_idx("dp_rs2_idx[0]", 5'd13, dp_rs2_idx[0]);
		check_idx("dp_dest_idx[0]", 5'd11, dp_dest_idx[0]);
		check_data("dp_pc[1]", last_pc + 32'd4, dp_pc[1]);
		check_alu("dp_alu_func[1]", dp_pkg::ALU_ADD, dp_alu_func[1]);
		check_fu("dp_fu_sel[1]", dp_pkg::FU_ALU, dp_fu_sel[1]);
		check_opa("dp_opa_sel[1]", dp_pkg::OPA_ZERO, dp_opa_sel[1]);
		check_opb("dp_opb_sel[1]", dp_pkg::OPB_IMM, dp_opb_sel[1]);
		check_data("dp_imm[1]", lui_imm, dp_imm[1]);
		check_idx("dp_rs1_idx[1]", 5'd0, dp_rs1_idx[1]);
		check_idx("dp_rs2_idx[1]", 5'd0, dp_rs2_idx[1]);
		check_idx("dp_dest_idx[1]", 5'd15, dp_dest_idx[1]);
		check_bit("dp_has_dest[1]", 1'b1, dp_has_dest[1]);
		@(posedge clock);
		spaces(2'd1, 2'd2, 2'd2); // room for one
		fetch(2'b11, enc_add(5'd11, 5'd12, 5'd13), i_lui);
		@(negedge clock);
		check_count("dp_count", 2'd1, dp_count);
		next_cycle();
		check_valid("dp_valid", 2'b01, dp_valid);
		check_idx("dp_dest_idx[0]", 5'd11, dp_dest_idx[0]);
		@(posedge clock);
		fetch(2'b01, i_lui, '0); // leftover lane moves down
		next_cycle();
		check_valid("dp_valid", 2'b01, dp_valid);
		check_opa("dp_opa_sel[0]", dp_pkg::OPA_ZERO, dp_opa_sel[0]);
		check_data("dp_imm[0]", lui_imm, dp_imm[0]);
		check_idx("dp_dest_idx[0]", 5'd15, dp_dest_idx[0]);
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial begin
		void'($urandom(32'ha591_7715));
		arst_n     = 1'b0;
		if_valid   = 2'b11; // lanes offered while in reset
		if_inst    = '0;
		if_pc      = '0;
		rt_valid   = '0;
		rt_idx     = '0;
		rt_data    = '0;
		rob_spaces = 2'd2;
		rs_spaces  = 2'd2;
		lsq_spaces = 2'd2;
		test_reset();
		test_decode();
		test_illegal();
		test_operands();
		test_count_sweep();
		test_backpressure();
		@(negedge clock);
		if (i_dp_stage.i_dp_assert.any_fail) begin
			abort("a bound assertion failed during the run");
		end else begin
			$display("=== PASS ===");
			$finish;
		end
	end

endmodule

/* tb.f */
common/isa_pkg.sv
common/dp_pkg.sv
verilog/regfile.sv
dispatch/dp_decoder.sv
dispatch/dp_ctrl.sv
dispatch/dp_stage.sv
verification/dp_assert.sv
verification/dp_tb.sv

/* Makefile */
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --assert --top-module dp_tb -f tb.f -o dp_sim
	./obj_dir/dp_sim | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
